// ==== Makefile ====
# Verilator build and run of the graphics pipeline testbench

VERILATOR ?= verilator
TOP       ?= graphics_pipeline_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
RUN_ARGS  ?=

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
rtl/gfx_pkg.sv
rtl/view_transform.sv
rtl/raster_fsm.sv
rtl/raster_scan_counter.sv
rtl/edge_eval.sv
rtl/graphics_pipeline.sv
verif/tb_clock_gen.sv
verif/graphics_pipeline_sva.sv
verif/graphics_pipeline_tb.sv

// ==== rtl/edge_eval.sv ====
// edge-function coverage test and registered pixel output of the rasterizer
`timescale 1ns/1ps

module edge_eval
  import gfx_pkg::*;
(
  input  logic                    clk_in,
  input  logic                    rst,
  input  logic                    setup,
  input  logic                    scan,
  input  scr_tri_t                scr_in,
  input  logic [HCOUNT_WIDTH-1:0] x,
  input  logic [VCOUNT_WIDTH-1:0] y,
  output logic                    advance,
  output logic                    area_zero,
  output logic                    pix_busy,
  output logic                    pix_valid,
  input  logic                    pix_ready,
  output pixel_t                  pix_data
);

  scr_t [2:0]             vx_q;
  scr_t [2:0]             vy_q;
  z_t                     z_q;
  logic [COLOR_WIDTH-1:0] color_q;
  scr_t                   px;
  scr_t                   py;
  edge_t [2:0]            edge_val;
  edge_t                  area2;
  logic                   covered;

  // cross product of (b - a) with (p - a)
  function automatic edge_t edge_fn(input scr_t ax, input scr_t ay, input scr_t bx,
                                    input scr_t by, input scr_t qx, input scr_t qy);
    return (bx - ax) * (qy - ay) - (by - ay) * (qx - ax);
  endfunction

  // twice the signed area, seen while the triangle is still held upstream
  assign area2     = edge_fn(scr_in.x[0], scr_in.y[0], scr_in.x[1], scr_in.y[1],
                             scr_in.x[2], scr_in.y[2]);
  assign area_zero = (area2 == '0);

  always_comb begin
    px          = scr_t'(x);  // zero extended
    py          = scr_t'(y);
    edge_val[0] = edge_fn(vx_q[0], vy_q[0], vx_q[1], vy_q[1], px, py);
    edge_val[1] = edge_fn(vx_q[1], vy_q[1], vx_q[2], vy_q[2], px, py);
    edge_val[2] = edge_fn(vx_q[2], vy_q[2], vx_q[0], vy_q[0], px, py);
    // either winding
    covered = ((edge_val[0] >= 0) && (edge_val[1] >= 0) && (edge_val[2] >= 0)) ||
              ((edge_val[0] <= 0) && (edge_val[1] <= 0) && (edge_val[2] <= 0));
  end

  assign pix_busy = pix_valid && !pix_ready;  // held, not taken this cycle
  assign advance  = scan && !pix_busy;

  always_ff @(posedge clk_in) begin
    if (setup) begin
      vx_q    <= scr_in.x;
      vy_q    <= scr_in.y;
      z_q     <= scr_in.z;
      color_q <= PALETTE[scr_in.tri_id[3:0]];
    end
    if (advance && covered) begin
      pix_data.hcount <= x;
      pix_data.vcount <= y;
      pix_data.addr   <= ADDR_WIDTH'(y) * ADDR_WIDTH'(FB_HRES) + ADDR_WIDTH'(x);
      pix_data.z      <= z_q;
      pix_data.color  <= color_q;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      pix_valid <= 1'b0;
    end else if (advance) begin
      pix_valid <= covered;  // refill or empty in the same cycle
    end else if (pix_ready) begin
      pix_valid <= 1'b0;
    end
  end

endmodule

// ==== rtl/gfx_pkg.sv ====
// shared widths, frame-buffer constants, palette and types; imported by every pipeline module
package gfx_pkg;

  localparam int P_WIDTH   = 16;  // vertex component
  localparam int C_WIDTH   = 18;  // camera component
  localparam int V_WIDTH   = 16;  // basis vector component
  localparam int FRAC_BITS = 14;  // basis fraction bits
  localparam int SCR_WIDTH = 12;  // signed viewport coordinate
  localparam int Z_WIDTH   = 20;

  localparam int FB_HRES = 32;
  localparam int FB_VRES = 24;

  localparam int HCOUNT_WIDTH = $clog2(FB_HRES);
  localparam int VCOUNT_WIDTH = $clog2(FB_VRES);
  localparam int ADDR_WIDTH   = $clog2(FB_HRES * FB_VRES);

  localparam int TRI_ID_WIDTH = 11;  // 2048 triangles
  localparam int COLOR_WIDTH  = 16;

  // camera-relative difference and the three-term dot product
  localparam int D_WIDTH    = C_WIDTH + 1;
  localparam int DOT_WIDTH  = D_WIDTH + V_WIDTH + 2;
  // edge function of two screen differences
  localparam int EDGE_WIDTH = 2 * (SCR_WIDTH + 1) + 1;

  typedef logic signed [P_WIDTH-1:0]    p_comp_t;
  typedef logic signed [C_WIDTH-1:0]    c_comp_t;
  typedef logic signed [V_WIDTH-1:0]    v_comp_t;
  typedef logic signed [D_WIDTH-1:0]    d_comp_t;
  typedef logic signed [SCR_WIDTH-1:0]  scr_t;
  typedef logic signed [Z_WIDTH-1:0]    z_t;
  typedef logic signed [EDGE_WIDTH-1:0] edge_t;

  localparam scr_t HALF_W = scr_t'(FB_HRES / 2);  // viewport center
  localparam scr_t HALF_H = scr_t'(FB_VRES / 2);
  localparam scr_t X_LAST = scr_t'(FB_HRES - 1);
  localparam scr_t Y_LAST = scr_t'(FB_VRES - 1);

  // rgb565 colors, selected by the low tri_id bits
  localparam logic [COLOR_WIDTH-1:0] PALETTE [16] = '{
    16'hf800, 16'h07e0, 16'h001f, 16'hffe0,
    16'hf81f, 16'h07ff, 16'hfd20, 16'h8010,
    16'h4208, 16'hc618, 16'h8400, 16'h0410,
    16'hfbea, 16'h2589, 16'h939b, 16'hffff
  };

  // component index 0 is x, 1 is y, 2 is z
  typedef struct packed {
    logic [TRI_ID_WIDTH-1:0] tri_id;
    p_comp_t [2:0][2:0]      p;  // p[vertex][axis]
    c_comp_t [2:0]           c;
    v_comp_t [2:0]           u;
    v_comp_t [2:0]           v;
    v_comp_t [2:0]           n;
  } tri_in_t;

  typedef struct packed {
    logic [TRI_ID_WIDTH-1:0] tri_id;
    scr_t [2:0]              x;
    scr_t [2:0]              y;
    z_t                      z;  // depth of vertex 0
  } scr_tri_t;

  typedef struct packed {
    logic [HCOUNT_WIDTH-1:0] xmin;
    logic [HCOUNT_WIDTH-1:0] xmax;
    logic [VCOUNT_WIDTH-1:0] ymin;
    logic [VCOUNT_WIDTH-1:0] ymax;
  } bbox_t;

  typedef struct packed {
    logic [HCOUNT_WIDTH-1:0] hcount;
    logic [VCOUNT_WIDTH-1:0] vcount;
    logic [ADDR_WIDTH-1:0]   addr;
    z_t                      z;
    logic [COLOR_WIDTH-1:0]  color;
  } pixel_t;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_SETUP,
    RS_SCAN,
    RS_DONE
  } raster_state_e;

endpackage

// ==== rtl/graphics_pipeline.sv ====
// triangle front end top: view transform feeding the rasterizer, valid/ready on both sides
`timescale 1ns/1ps

module graphics_pipeline
  import gfx_pkg::*;
(
  input  logic    clk_in,
  input  logic    rst,
  input  logic    tri_valid,
  output logic    tri_ready,
  input  tri_in_t tri_data,
  output logic    pix_valid,
  input  logic    pix_ready,
  output pixel_t  pix_data,
  output logic    tri_done
);

  scr_tri_t                scr_tri;
  logic                    scr_valid;
  logic                    scr_ready;  // rasterizer idle
  logic                    setup;
  logic                    scan;
  logic                    scan_last;
  logic                    box_empty;
  logic                    area_zero;
  logic                    pix_busy;
  logic                    advance;
  logic [HCOUNT_WIDTH-1:0] scan_x;
  logic [VCOUNT_WIDTH-1:0] scan_y;

  view_transform u_view_transform (
    .clk_in   (clk_in),
    .rst      (rst),
    .in_valid (tri_valid),
    .in_ready (tri_ready),
    .in_tri   (tri_data),
    .out_valid(scr_valid),
    .out_ready(scr_ready),
    .out_tri  (scr_tri)
  );

  raster_fsm u_raster_fsm (
    .clk_in   (clk_in),
    .rst      (rst),
    .tri_valid(scr_valid),
    .tri_ready(scr_ready),
    .setup    (setup),
    .scan     (scan),
    .scan_last(scan_last),
    .box_empty(box_empty),
    .area_zero(area_zero),
    .pix_busy (pix_busy),
    .tri_done (tri_done)
  );

  // box only feeds the counter's own wrap and last-pixel logic
  raster_scan_counter u_raster_scan_counter (
    .clk_in   (clk_in),
    .rst      (rst),
    .setup    (setup),
    .scr_in   (scr_tri),
    .advance  (advance),
    .box      (),
    .x        (scan_x),
    .y        (scan_y),
    .box_empty(box_empty),
    .scan_last(scan_last)
  );

  edge_eval u_edge_eval (
    .clk_in   (clk_in),
    .rst      (rst),
    .setup    (setup),
    .scan     (scan),
    .scr_in   (scr_tri),
    .x        (scan_x),
    .y        (scan_y),
    .advance  (advance),
    .area_zero(area_zero),
    .pix_busy (pix_busy),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .pix_data (pix_data)
  );

endmodule

// ==== rtl/raster_fsm.sv ====
// rasterizer control: accept a screen triangle, set up, scan the box, pulse done
`timescale 1ns/1ps

module raster_fsm
  import gfx_pkg::*;
(
  input  logic clk_in,
  input  logic rst,
  input  logic tri_valid,
  output logic tri_ready,
  output logic setup,
  output logic scan,
  input  logic scan_last,
  input  logic box_empty,
  input  logic area_zero,
  input  logic pix_busy,
  output logic tri_done
);

  raster_state_e state;
  raster_state_e state_nxt;
  logic          last_seen;  // final box pixel already evaluated

  assign tri_ready = (state == RS_IDLE);
  assign setup     = (state == RS_SETUP);
  assign scan      = (state == RS_SCAN) && !last_seen;
  assign tri_done  = (state == RS_DONE);

  always_comb begin
    state_nxt = state;
    case (state)
      RS_IDLE: begin
        if (tri_valid) state_nxt = RS_SETUP;
      end
      RS_SETUP: begin
        // nothing to draw, skip the scan
        state_nxt = (box_empty || area_zero) ? RS_DONE : RS_SCAN;
      end
      RS_SCAN: begin
        if (last_seen && !pix_busy) state_nxt = RS_DONE;  // output drained
      end
      RS_DONE: state_nxt = RS_IDLE;
      default: state_nxt = RS_IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      state     <= RS_IDLE;
      last_seen <= 1'b0;
    end else begin
      state <= state_nxt;
      if (setup) begin
        last_seen <= 1'b0;
      end else if (scan && scan_last && !pix_busy) begin
        last_seen <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/raster_scan_counter.sv ====
// clamped bounding box setup and raster-order x/y counter for the rasterizer
`timescale 1ns/1ps

module raster_scan_counter
  import gfx_pkg::*;
(
  input  logic                    clk_in,
  input  logic                    rst,
  input  logic                    setup,
  input  scr_tri_t                scr_in,
  input  logic                    advance,
  output bbox_t                   box,
  output logic [HCOUNT_WIDTH-1:0] x,
  output logic [VCOUNT_WIDTH-1:0] y,
  output logic                    box_empty,
  output logic                    scan_last
);

  scr_t  xmin_raw;
  scr_t  xmax_raw;
  scr_t  ymin_raw;
  scr_t  ymax_raw;
  bbox_t box_c;

  function automatic scr_t min3(input scr_t a, input scr_t b, input scr_t c);
    scr_t m;
    m = (a < b) ? a : b;
    return (c < m) ? c : m;
  endfunction

  function automatic scr_t max3(input scr_t a, input scr_t b, input scr_t c);
    scr_t m;
    m = (a > b) ? a : b;
    return (c > m) ? c : m;
  endfunction

  function automatic scr_t clamp(input scr_t a, input scr_t hi);
    if (a < 0) return '0;
    if (a > hi) return hi;
    return a;
  endfunction

  always_comb begin
    xmin_raw   = min3(scr_in.x[0], scr_in.x[1], scr_in.x[2]);
    xmax_raw   = max3(scr_in.x[0], scr_in.x[1], scr_in.x[2]);
    ymin_raw   = min3(scr_in.y[0], scr_in.y[1], scr_in.y[2]);
    ymax_raw   = max3(scr_in.y[0], scr_in.y[1], scr_in.y[2]);
    box_c.xmin = HCOUNT_WIDTH'(clamp(xmin_raw, X_LAST));
    box_c.xmax = HCOUNT_WIDTH'(clamp(xmax_raw, X_LAST));
    box_c.ymin = VCOUNT_WIDTH'(clamp(ymin_raw, Y_LAST));
    box_c.ymax = VCOUNT_WIDTH'(clamp(ymax_raw, Y_LAST));
  end

  // box lies entirely off the frame buffer
  assign box_empty = (xmax_raw < 0) || (xmin_raw > X_LAST) ||
                     (ymax_raw < 0) || (ymin_raw > Y_LAST);
  assign scan_last = (x == box.xmax) && (y == box.ymax);

  always_ff @(posedge clk_in) begin
    if (setup) box <= box_c;
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      x <= '0;
      y <= '0;
    end else if (setup) begin
      x <= box_c.xmin;
      y <= box_c.ymin;
    end else if (advance) begin
      if (x == box.xmax) begin  // end of row
        x <= box.xmin;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/view_transform.sv ====
// camera-space projection of a triangle into viewport coordinates, one vertex per cycle
`timescale 1ns/1ps

module view_transform
  import gfx_pkg::*;
(
  input  logic     clk_in,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  tri_in_t  in_tri,
  output logic     out_valid,
  input  logic     out_ready,
  output scr_tri_t out_tri
);

  tri_in_t                     tri_q;
  logic [1:0]                  vtx_idx;
  logic                        busy;
  p_comp_t [2:0]               cur_p;
  d_comp_t [2:0]               diff;
  logic signed [DOT_WIDTH-1:0] dot_u;
  logic signed [DOT_WIDTH-1:0] dot_v;
  logic signed [DOT_WIDTH-1:0] dot_n;
  scr_t                        proj_u;
  scr_t                        proj_v;
  z_t                          proj_n;

  function automatic logic signed [DOT_WIDTH-1:0] dot3(input d_comp_t [2:0] a,
                                                       input v_comp_t [2:0] b);
    return a[0] * b[0] + a[1] * b[1] + a[2] * b[2];
  endfunction

  // three multiplies per basis vector for the current vertex
  always_comb begin
    cur_p = tri_q.p[vtx_idx];
    for (int a = 0; a < 3; a++) begin
      diff[a] = cur_p[a] - tri_q.c[a];
    end
    dot_u  = dot3(diff, tri_q.u);
    dot_v  = dot3(diff, tri_q.v);
    dot_n  = dot3(diff, tri_q.n);
    proj_u = scr_t'(dot_u >>> FRAC_BITS);  // drop fraction, keep low bits
    proj_v = scr_t'(dot_v >>> FRAC_BITS);
    proj_n = z_t'(dot_n >>> FRAC_BITS);
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      busy      <= 1'b0;
      vtx_idx   <= 2'd0;
      out_valid <= 1'b0;
      in_ready  <= 1'b0;
    end else begin
      if (in_valid && in_ready) begin
        busy     <= 1'b1;
        vtx_idx  <= 2'd0;
        in_ready <= 1'b0;
      end else if (busy) begin
        vtx_idx <= vtx_idx + 2'd1;
        if (vtx_idx == 2'd2) begin  // third vertex written this cycle
          busy      <= 1'b0;
          out_valid <= 1'b1;
        end
      end else if (out_valid && out_ready) begin
        out_valid <= 1'b0;
        in_ready  <= 1'b1;
      end else if (!out_valid) begin
        in_ready <= 1'b1;  // idle and empty
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (in_valid && in_ready) begin
      tri_q <= in_tri;
    end
    if (busy) begin
      out_tri.x[vtx_idx] <= proj_u + HALF_W;
      out_tri.y[vtx_idx] <= HALF_H - proj_v;  // screen y grows downward
      if (vtx_idx == 2'd0) begin
        out_tri.tri_id <= tri_q.tri_id;
        out_tri.z      <= proj_n;  // flat depth from vertex 0
      end
    end
  end

endmodule

// ==== verif/graphics_pipeline_sva.sv ====
// handshake and reset assertions, bound onto the pipeline top level from the testbench
`timescale 1ns/1ps

module graphics_pipeline_sva
  import gfx_pkg::*;
(
  input logic    clk_in,
  input logic    rst,
  input logic    tri_valid,
  input logic    tri_ready,
  input tri_in_t tri_data,
  input logic    pix_valid,
  input logic    pix_ready,
  input pixel_t  pix_data,
  input logic    tri_done
);

  // offered triangle stays put until taken
  property tri_hold_p;
    @(posedge clk_in) disable iff (rst)
      tri_valid && !tri_ready |=> tri_valid && $stable(tri_data);
  endproperty

  property pix_hold_p;
    @(posedge clk_in) disable iff (rst)
      pix_valid && !pix_ready |=> pix_valid && $stable(pix_data);
  endproperty

  property reset_quiet_p;
    @(posedge clk_in) rst |=> !pix_valid && !tri_done;
  endproperty

  // done is a single-cycle pulse
  property done_pulse_p;
    @(posedge clk_in) disable iff (rst) tri_done |=> !tri_done;
  endproperty

  tri_hold_a: assert property (tri_hold_p) else $error("triangle offer changed before acceptance");
  pix_hold_a: assert property (pix_hold_p) else $error("pixel record changed while held");
  reset_quiet_a: assert property (reset_quiet_p) else $error("pixel or done active in reset");
  done_pulse_a: assert property (done_pulse_p) else $error("tri_done high for two cycles");

endmodule

// ==== verif/graphics_pipeline_tb.sv ====
// top-level testbench that checks random triangles on the front end pixel by pixel against a model
`timescale 1ns/1ps

module graphics_pipeline_tb
  import gfx_pkg::*;
();

  localparam int NUM_TRI = 200;
  localparam int TIMEOUT = 5000;  // cycles allowed per wait

  logic    clk_in;
  logic    rst;
  logic    tri_valid;
  logic    tri_ready;
  tri_in_t tri_data;
  logic    pix_valid;
  logic    pix_ready;
  pixel_t  pix_data;
  logic    tri_done;

  int      seed = 32'hc7ec_a814;
  int      ready_seed = 32'hc7ec_a814;  // separate stream for back-pressure
  logic    stall_mode = 1'b0;
  pixel_t  exp_pix_q[$];
  int      exp_cnt_q[$];  // pixel count per triangle in send order
  int      accept_cnt = 0;
  int      done_cnt = 0;
  int      overlap_cnt = 0;
  int      held_cnt = 0;
  int      clip_cnt = 0;

  tb_clock_gen u_clock_gen (.clk_in(clk_in), .rst(rst));

  graphics_pipeline DUT (
    .clk_in   (clk_in),
    .rst      (rst),
    .tri_valid(tri_valid),
    .tri_ready(tri_ready),
    .tri_data (tri_data),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .pix_data (pix_data),
    .tri_done (tri_done)
  );

  bind graphics_pipeline graphics_pipeline_sva u_sva (
    .clk_in(clk_in), .rst(rst), .tri_valid(tri_valid), .tri_ready(tri_ready),
    .tri_data(tri_data), .pix_valid(pix_valid), .pix_ready(pix_ready),
    .pix_data(pix_data), .tri_done(tri_done)
  );

  task automatic end_with_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, want);
      end_with_failure();
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + int'($unsigned(r) % (hi - lo + 1));
  endfunction

  // two's complement wrap to w bits
  function automatic longint wrap_signed(input longint v, input int w);
    longint m;
    m = v & ((longint'(1) << w) - 1);
    if (m >= (longint'(1) << (w - 1))) m = m - (longint'(1) << w);
    return m;
  endfunction

  function automatic longint edge_cross(input longint ax, input longint ay, input longint bx,
                                        input longint by, input longint qx, input longint qy);
    return (bx - ax) * (qy - ay) - (by - ay) * (qx - ax);
  endfunction

  task automatic make_triangle(input int idx, output tri_in_t t);
    t.tri_id = TRI_ID_WIDTH'(rand_range(0, 2047));
    for (int a = 0; a < 3; a++) begin
      t.c[a] = C_WIDTH'(rand_range(-4000, 4000));
      t.u[a] = V_WIDTH'(rand_range(-16384, 16384));  // about +-1.0
      t.v[a] = V_WIDTH'(rand_range(-16384, 16384));
      t.n[a] = V_WIDTH'(rand_range(-16384, 16384));
    end
    for (int k = 0; k < 3; k++) begin
      for (int a = 0; a < 3; a++) begin
        t.p[k][a] = P_WIDTH'(longint'($signed(t.c[a])) + rand_range(-10, 10));
      end
    end
    if (idx % 25 == 7) t.p[2] = t.p[1];  // zero area
  endtask

  // expected pixels from projection, clamped box and coverage
  task automatic build_expected(input tri_in_t t);
    longint sx[3];
    longint sy[3];
    longint sz;
    longint d[3];
    longint pu, pv, pn;
    longint xlo, xhi, ylo, yhi;
    longint e0, e1, e2, area;
    int     x0, x1, y0, y1;
    int     count;
    pixel_t px;
    sz = 0;
    for (int k = 0; k < 3; k++) begin
      pu = 0;
      pv = 0;
      pn = 0;
      for (int a = 0; a < 3; a++) begin
        d[a] = longint'($signed(t.p[k][a])) - longint'($signed(t.c[a]));
        pu += d[a] * longint'($signed(t.u[a]));
        pv += d[a] * longint'($signed(t.v[a]));
        pn += d[a] * longint'($signed(t.n[a]));
      end
      sx[k] = wrap_signed(wrap_signed(pu >>> FRAC_BITS, SCR_WIDTH) + FB_HRES / 2, SCR_WIDTH);
      sy[k] = wrap_signed(FB_VRES / 2 - wrap_signed(pv >>> FRAC_BITS, SCR_WIDTH), SCR_WIDTH);
      if (k == 0) sz = wrap_signed(pn >>> FRAC_BITS, Z_WIDTH);
    end
    xlo = sx[0];
    xhi = sx[0];
    ylo = sy[0];
    yhi = sy[0];
    for (int k = 1; k < 3; k++) begin
      if (sx[k] < xlo) xlo = sx[k];
      if (sx[k] > xhi) xhi = sx[k];
      if (sy[k] < ylo) ylo = sy[k];
      if (sy[k] > yhi) yhi = sy[k];
    end
    area = edge_cross(sx[0], sy[0], sx[1], sy[1], sx[2], sy[2]);
    count = 0;
    if (area != 0 && xhi >= 0 && xlo < FB_HRES && yhi >= 0 && ylo < FB_VRES) begin
      x0 = (xlo < 0) ? 0 : int'(xlo);
      x1 = (xhi >= FB_HRES) ? FB_HRES - 1 : int'(xhi);
      y0 = (ylo < 0) ? 0 : int'(ylo);
      y1 = (yhi >= FB_VRES) ? FB_VRES - 1 : int'(yhi);
      for (int y = y0; y <= y1; y++) begin
        for (int x = x0; x <= x1; x++) begin
          e0 = edge_cross(sx[0], sy[0], sx[1], sy[1], x, y);
          e1 = edge_cross(sx[1], sy[1], sx[2], sy[2], x, y);
          e2 = edge_cross(sx[2], sy[2], sx[0], sy[0], x, y);
          if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0)) begin
            px.hcount = HCOUNT_WIDTH'(x);
            px.vcount = VCOUNT_WIDTH'(y);
            px.addr   = ADDR_WIDTH'(y * FB_HRES + x);
            px.z      = Z_WIDTH'(sz);
            px.color  = PALETTE[t.tri_id[3:0]];
            exp_pix_q.push_back(px);
            count++;
          end
        end
      end
      if (count > 0 && (xlo < 0 || xhi >= FB_HRES || ylo < 0 || yhi >= FB_VRES)) clip_cnt++;
    end
    exp_cnt_q.push_back(count);
  endtask

  initial begin : ready_drive
    int roll;
    pix_ready = 1'b0;
    forever begin
      @(negedge clk_in);
      roll = $random(ready_seed);
      if (stall_mode) pix_ready = ($unsigned(roll) % 10) >= 4;  // low about 40 percent
      else pix_ready = 1'b1;
    end
  end

  // samples at the rising edge before registered outputs update
  initial begin : monitor
    int     left;
    logic   holding;
    pixel_t held;
    pixel_t want;
    left = -1;  // no triangle loaded
    holding = 1'b0;
    forever begin
      @(posedge clk_in);
      if (rst === 1'b0) begin
        if (holding) begin
          check_value("pix_valid", pix_valid, 1'b1);
          check_value("pix_data", pix_data, held);
        end
        holding = pix_valid && !pix_ready;
        held = pix_data;
        if (holding) held_cnt++;
        if (tri_valid && tri_ready) begin
          if (accept_cnt > done_cnt) overlap_cnt++;  // earlier triangle still rasterizing
          accept_cnt++;
        end
        if ((pix_valid && pix_ready) || tri_done) begin
          if (left < 0) begin
            if (exp_cnt_q.size() == 0) begin
              $display("pixel or tri_done seen with no triangle sent");
              end_with_failure();
            end
            left = exp_cnt_q.pop_front();
          end
        end
        if (pix_valid && pix_ready) begin
          if (left == 0) begin
            $display("more pixels than the model expects for triangle %0d", done_cnt);
            end_with_failure();
          end
          want = exp_pix_q.pop_front();
          check_value("pix_data.hcount", pix_data.hcount, want.hcount);
          check_value("pix_data.vcount", pix_data.vcount, want.vcount);
          check_value("pix_data.addr", pix_data.addr, want.addr);
          check_value("pix_data.z", pix_data.z, want.z);
          check_value("pix_data.color", pix_data.color, want.color);
          left--;
        end
        if (tri_done) begin
          if (left != 0 || done_cnt >= accept_cnt) begin
            $display("tri_done for triangle %0d with %0d pixels still missing", done_cnt, left);
            end_with_failure();
          end
          done_cnt++;
          left = -1;
        end
      end
    end
  end

  initial begin : driver
    tri_in_t t;
    int      wait_cnt;
    int      gap;
    tri_valid = 1'b0;
    tri_data  = '0;
    wait_cnt  = 0;
    while (rst !== 1'b0) begin
      @(negedge clk_in);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        $display("reset was never released");
        end_with_failure();
      end
    end
    check_value("tri_ready", tri_ready, 1'b0);  // first cycle out of reset
    check_value("pix_valid", pix_valid, 1'b0);
    check_value("tri_done", tri_done, 1'b0);
    for (int i = 0; i < NUM_TRI; i++) begin
      if (i == NUM_TRI / 2) stall_mode <= 1'b1;
      make_triangle(i, t);
      build_expected(t);
      tri_valid = 1'b1;
      tri_data  = t;
      wait_cnt  = 0;
      while (!tri_ready) begin
        @(negedge clk_in);
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          $display("timeout waiting for tri_ready on triangle %0d", i);
          end_with_failure();
        end
      end
      @(negedge clk_in);  // taken at the edge just passed
      tri_valid = 1'b0;
      gap = ((i % 100) < 50) ? rand_range(0, 4) : 0;  // second half of each block back to back
      repeat (gap) @(negedge clk_in);
    end
    wait_cnt = 0;
    while (done_cnt < NUM_TRI) begin
      @(negedge clk_in);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        $display("timeout waiting for tri_done, %0d of %0d seen", done_cnt, NUM_TRI);
        end_with_failure();
      end
    end
    repeat (8) @(negedge clk_in);  // room for a stray pixel or done
    if (exp_pix_q.size() == 0 && exp_cnt_q.size() == 0 && overlap_cnt > 0 &&
        held_cnt > 0 && clip_cnt > 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("end of run: %0d pixels left, %0d overlaps, %0d stalls, %0d clipped",
               exp_pix_q.size(), overlap_cnt, held_cnt, clip_cnt);
      end_with_failure();
    end
  end

endmodule

// ==== verif/tb_clock_gen.sv ====
// testbench clock and reset source, 4 ns clock with reset held over the first 10 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_in,
  output logic rst
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_in = 1'b0;
    forever #HALF_PERIOD clk_in = ~clk_in;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_in);
    rst <= 1'b0;  // drops right after the tenth edge
  end

endmodule
